// File: umi_fifo_flex.f
+incdir+tests
src/umi_flex_pkg.sv
src/umi_pkt_if.sv
src/umi_split_ctrl.sv
src/umi_split_beat.sv
src/umi_split_latch.sv
src/umi_beat_fifo.sv
src/umi_fifo_flex.sv
tests/tb_umi_fifo_flex.sv

// File: Makefile
# Verilator build, run, lint and clean for the UMI width converter

VERILATOR ?= verilator
TOP       ?= tb_umi_fifo_flex
FILELIST  ?= umi_fifo_flex.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -j $(JOBS) \
		--top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation binary gives pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_umi_vectors.svh
// Stimulus rows for the width converter testbench, applied in order.
// Columns: size, len, eom, dstaddr, srcaddr, bypass, stall
// A stall row holds umi_out_ready low until the FIFO reports full.

`ifndef TB_UMI_VECTORS_SVH
`define TB_UMI_VECTORS_SVH

typedef struct packed {
   logic [2:0]              size;
   logic [7:0]              len;
   logic                    eom;
   umi_flex_pkg::umi_addr_t dstaddr;
   umi_flex_pkg::umi_addr_t srcaddr;
   logic                    bypass;
   logic                    stall;
} vec_row_t;

localparam int NUM_ROWS = 12;

localparam vec_row_t VECTORS [NUM_ROWS] = '{
   '{3'd3, 8'd0,  1'b1, 64'h0000_0000_0000_1000, 64'h0000_0000_8000_0000, 1'b0, 1'b0},
   '{3'd0, 8'd7,  1'b1, 64'h0000_0000_0000_2008, 64'h0000_0000_8000_0100, 1'b0, 1'b0},
   '{3'd2, 8'd3,  1'b1, 64'h0000_0000_FFFF_FFF8, 64'h0000_0001_0000_0000, 1'b0, 1'b0},
   '{3'd1, 8'd11, 1'b0, 64'h0000_0000_0000_3010, 64'h0000_0000_8000_0200, 1'b0, 1'b0},
   '{3'd0, 8'd31, 1'b1, 64'h0000_0000_0000_4000, 64'hFFFF_FFFF_FFFF_FFF0, 1'b0, 1'b0},
   '{3'd3, 8'd3,  1'b1, 64'h0000_0000_0000_5000, 64'h0000_0000_8000_0300, 1'b0, 1'b1},
   '{3'd2, 8'd7,  1'b0, 64'h0000_0000_0000_6020, 64'h0000_0000_8000_0400, 1'b0, 1'b1},
   '{3'd3, 8'd0,  1'b1, 64'h0000_0000_0000_7000, 64'h0000_0000_8000_0500, 1'b1, 1'b0},
   '{3'd2, 8'd3,  1'b1, 64'h0000_0000_FFFF_FFF8, 64'h0000_0000_8000_0600, 1'b1, 1'b0},
   '{3'd1, 8'd11, 1'b1, 64'h0000_0000_0000_8010, 64'h0000_0000_8000_0700, 1'b1, 1'b0},
   '{3'd0, 8'd31, 1'b0, 64'h0000_0000_0000_9000, 64'hFFFF_FFFF_FFFF_FFF0, 1'b1, 1'b0},
   '{3'd1, 8'd2,  1'b1, 64'h0000_0000_0000_A004, 64'h0000_0000_8000_0800, 1'b0, 1'b0}
};

`endif

// File: tests/tb_umi_fifo_flex.sv
// Testbench for the UMI down-sizing width converter.
// Sends table packets with LFSR data, expands each packet into its
// expected 64-bit beats and checks them at the output in FIFO and bypass
// modes, with random output ready and a full-FIFO stall phase.

`default_nettype none
`timescale 1ns/100ps

module tb_umi_fifo_flex;

   localparam int TIMEOUT = 200;

   typedef struct packed {
      umi_flex_pkg::umi_cmd_t  cmd;
      umi_flex_pkg::umi_addr_t dst;
      umi_flex_pkg::umi_addr_t src;
      umi_flex_pkg::out_data_t data;
   } beat_t;

   `include "tb_umi_vectors.svh"

   logic                    umi_in_clk;
   logic                    umi_in_nreset;
   logic                    bypass;
   logic                    umi_in_valid;
   umi_flex_pkg::umi_cmd_t  umi_in_cmd;
   umi_flex_pkg::umi_addr_t umi_in_dstaddr;
   umi_flex_pkg::umi_addr_t umi_in_srcaddr;
   umi_flex_pkg::in_data_t  umi_in_data;
   logic                    umi_in_ready;
   logic                    umi_out_valid;
   umi_flex_pkg::umi_cmd_t  umi_out_cmd;
   umi_flex_pkg::umi_addr_t umi_out_dstaddr;
   umi_flex_pkg::umi_addr_t umi_out_srcaddr;
   umi_flex_pkg::out_data_t umi_out_data;
   logic                    umi_out_ready;
   logic                    fifo_full;
   logic                    fifo_empty;

   logic [15:0] lfsr_state = 16'd59795;
   logic        stall = 1'b0;
   beat_t       exp_q [$];

   umi_fifo_flex u_umi_fifo_flex (.*);

   initial
   begin
      umi_in_clk = 1'b0;
      forever #2 umi_in_clk = ~umi_in_clk;
   end

   // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_next_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
         lfsr_state = lfsr_state ^ 16'hB400;
      return out;
   endfunction

   // Random output ready unless a stall is in progress
   initial
   begin
      umi_out_ready = 1'b0;
      forever
      begin
         @(posedge umi_in_clk);
         #1;
         if (stall)
            umi_out_ready = 1'b0;
         else
            umi_out_ready = lfsr_next_bit();
      end
   end

   // ##############################
   // Checks
   // ##############################
   task automatic abort_run(input string why);
      if (why != "")
         $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check_cmd(input string name, input umi_flex_pkg::umi_cmd_t exp,
                            input umi_flex_pkg::umi_cmd_t act);
      if (act !== exp)
      begin
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
         abort_run("");
      end
   endtask

   task automatic check_addr(input string name, input umi_flex_pkg::umi_addr_t exp,
                             input umi_flex_pkg::umi_addr_t act);
      if (act !== exp)
      begin
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
         abort_run("");
      end
   endtask

   task automatic check_data(input string name, input umi_flex_pkg::out_data_t exp,
                             input umi_flex_pkg::out_data_t act);
      if (act !== exp)
      begin
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
         abort_run("");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
         abort_run("");
      end
   endtask

   // ##############################
   // Stimulus and reference model
   // ##############################
   function automatic umi_flex_pkg::umi_cmd_t make_cmd(input vec_row_t row, input int idx);
      umi_flex_pkg::umi_cmd_t cmd;
      cmd        = '0;
      cmd.opcode = 5'(idx + 1);
      cmd.size   = row.size;
      cmd.len    = row.len;
      cmd.eom    = row.eom;
      cmd.qos    = 4'(idx);
      cmd.hostid = 3'(idx);
      cmd.prot   = 2'(idx);
      cmd.user   = 2'(idx >> 1);
      cmd.err    = 2'(idx >> 2);
      cmd.ex     = idx[0];
      cmd.eof    = idx[1];
      return cmd;
   endfunction

   task automatic random_data(output umi_flex_pkg::in_data_t d);
      for (int i = 0; i < umi_flex_pkg::IDW; i++)
         d[i] = lfsr_next_bit();
   endtask

   // Full 8-byte beats with eom low and then the remainder
   task automatic build_expected(input umi_flex_pkg::umi_cmd_t cmd_in, input vec_row_t row,
                                 input umi_flex_pkg::in_data_t data);
      umi_flex_pkg::umi_cmd_t  cmd;
      umi_flex_pkg::umi_addr_t dst;
      umi_flex_pkg::umi_addr_t src;
      umi_flex_pkg::in_data_t  d;
      beat_t                   b;
      int                      per_beat;
      int                      bytes_left;
      cmd        = cmd_in;
      dst        = row.dstaddr;
      src        = row.srcaddr;
      d          = data;
      per_beat   = 8 >> row.size;
      bytes_left = (int'(row.len) + 1) << row.size;
      while (bytes_left > umi_flex_pkg::ODW_BYTES)
      begin
         b.cmd     = cmd;
         b.cmd.len = 8'(per_beat - 1);
         b.cmd.eom = 1'b0;
         b.dst     = dst;
         b.src     = src;
         b.data    = d[umi_flex_pkg::ODW-1:0];
         exp_q.push_back(b);
         cmd.len    = cmd.len - 8'(per_beat);
         dst        = dst + 64'd8;
         src        = src + 64'd8;
         d          = d >> umi_flex_pkg::ODW;
         bytes_left = bytes_left - 8;
      end
      b.cmd  = cmd;
      b.dst  = dst;
      b.src  = src;
      b.data = d[umi_flex_pkg::ODW-1:0];
      exp_q.push_back(b);
   endtask

   task automatic send_packet(input umi_flex_pkg::umi_cmd_t cmd, input vec_row_t row,
                              input umi_flex_pkg::in_data_t data);
      int waited;
      waited = 0;
      @(posedge umi_in_clk);
      #1;
      bypass         = row.bypass;
      umi_in_valid   = 1'b1;
      umi_in_cmd     = cmd;
      umi_in_dstaddr = row.dstaddr;
      umi_in_srcaddr = row.srcaddr;
      umi_in_data    = data;
      @(negedge umi_in_clk);
      while (!umi_in_ready)
      begin
         waited++;
         if (waited > TIMEOUT)
            abort_run("Timeout: input packet was never accepted");
         @(negedge umi_in_clk);
      end
      @(posedge umi_in_clk);
      #1;
      umi_in_valid = 1'b0;
   endtask

   // Outputs are sampled on the falling edge between drive points
   task automatic collect_beats();
      beat_t b;
      int    waited;
      waited = 0;
      while (exp_q.size() > 0)
      begin
         @(negedge umi_in_clk);
         if (bypass)
            check_bit("fifo_empty", 1'b1, fifo_empty);
         if (umi_out_valid && umi_out_ready)
         begin
            b = exp_q.pop_front();
            check_cmd("umi_out_cmd", b.cmd, umi_out_cmd);
            check_addr("umi_out_dstaddr", b.dst, umi_out_dstaddr);
            check_addr("umi_out_srcaddr", b.src, umi_out_srcaddr);
            check_data("umi_out_data", b.data, umi_out_data);
            waited = 0;
         end
         else
         begin
            waited++;
            if (waited > TIMEOUT)
               abort_run("Timeout: expected output beat did not arrive");
         end
      end
   endtask

   // With the output stalled one beat enters the FIFO per cycle
   task automatic wait_full();
      int waited;
      waited = 0;
      @(negedge umi_in_clk);
      while (fifo_empty)
      begin
         waited++;
         if (waited > TIMEOUT)
            abort_run("Timeout: no beat reached the FIFO while output was stalled");
         @(negedge umi_in_clk);
      end
      for (int n = 1; n < umi_flex_pkg::FIFO_DEPTH; n++)
      begin
         check_bit("fifo_full", 1'b0, fifo_full);
         @(negedge umi_in_clk);
      end
      check_bit("fifo_full", 1'b1, fifo_full);
      check_bit("umi_in_ready", 1'b0, umi_in_ready);
      check_bit("fifo_empty", 1'b0, fifo_empty);
      stall = 1'b0;
   endtask

   // ##############################
   // Main sequence
   // ##############################
   initial
   begin
      umi_flex_pkg::in_data_t data;
      umi_flex_pkg::umi_cmd_t cmd;
      umi_in_nreset  = 1'b0;
      bypass         = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      repeat (3) @(posedge umi_in_clk);
      #1;
      umi_in_nreset = 1'b1;

      // State right after reset
      @(negedge umi_in_clk);
      check_bit("umi_out_valid", 1'b0, umi_out_valid);
      check_bit("fifo_empty", 1'b1, fifo_empty);
      check_bit("fifo_full", 1'b0, fifo_full);
      check_bit("umi_in_ready", 1'b1, umi_in_ready);

      for (int r = 0; r < NUM_ROWS; r++)
      begin
         random_data(data);
         cmd = make_cmd(VECTORS[r], r);
         build_expected(cmd, VECTORS[r], data);
         stall = VECTORS[r].stall;
         fork
            send_packet(cmd, VECTORS[r], data);
            collect_beats();
            if (VECTORS[r].stall)
               wait_full();
         join
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/umi_fifo_flex.sv
// UMI width converter from a 256-bit input bus to a 64-bit output bus.
// Packets larger than one output beat are split into 8-byte beats, which
// leave through a 4-entry FIFO or, with bypass high, combinationally.
// Single clock domain; bypass may change only when idle.

`default_nettype none
`timescale 1ns/100ps

module umi_fifo_flex (
   input  logic                     umi_in_clk,
   input  logic                     umi_in_nreset,
   input  logic                     bypass,
   output logic                     fifo_full,
   output logic                     fifo_empty,
   // Input side
   input  logic                     umi_in_valid,
   input  umi_flex_pkg::umi_cmd_t   umi_in_cmd,
   input  umi_flex_pkg::umi_addr_t  umi_in_dstaddr,
   input  umi_flex_pkg::umi_addr_t  umi_in_srcaddr,
   input  umi_flex_pkg::in_data_t   umi_in_data,
   output logic                     umi_in_ready,
   // Output side
   output logic                     umi_out_valid,
   output umi_flex_pkg::umi_cmd_t   umi_out_cmd,
   output umi_flex_pkg::umi_addr_t  umi_out_dstaddr,
   output umi_flex_pkg::umi_addr_t  umi_out_srcaddr,
   output umi_flex_pkg::out_data_t  umi_out_data,
   input  logic                     umi_out_ready
);

   logic beat_valid;
   logic use_held;
   logic load;
   logic needs_split;
   logic beat_room;

   umi_pkt_if #(.data_t(umi_flex_pkg::in_data_t))  in_if ();
   umi_pkt_if #(.data_t(umi_flex_pkg::in_data_t))  held_if ();
   umi_pkt_if #(.data_t(umi_flex_pkg::in_data_t))  rem_if ();
   umi_pkt_if #(.data_t(umi_flex_pkg::out_data_t)) beat_if ();

   // Input packet into the bundle
   assign in_if.cmd     = umi_in_cmd;
   assign in_if.dstaddr = umi_in_dstaddr;
   assign in_if.srcaddr = umi_in_srcaddr;
   assign in_if.data    = umi_in_data;

   umi_split_ctrl u_ctrl (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .umi_in_valid  (umi_in_valid),
      .needs_split   (needs_split),
      .beat_room     (beat_room),
      .umi_in_ready  (umi_in_ready),
      .beat_valid    (beat_valid),
      .use_held      (use_held),
      .load          (load)
   );

   umi_split_beat u_beat (
      .use_held    (use_held),
      .pkt_in      (in_if),
      .held        (held_if),
      .needs_split (needs_split),
      .beat        (beat_if),
      .rem         (rem_if)
   );

   umi_split_latch u_latch (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .load          (load),
      .rem           (rem_if),
      .held          (held_if)
   );

   umi_beat_fifo u_fifo (
      .umi_in_clk      (umi_in_clk),
      .umi_in_nreset   (umi_in_nreset),
      .bypass          (bypass),
      .beat_valid      (beat_valid),
      .umi_out_ready   (umi_out_ready),
      .beat            (beat_if),
      .beat_room       (beat_room),
      .fifo_full       (fifo_full),
      .fifo_empty      (fifo_empty),
      .umi_out_valid   (umi_out_valid),
      .umi_out_cmd     (umi_out_cmd),
      .umi_out_dstaddr (umi_out_dstaddr),
      .umi_out_srcaddr (umi_out_srcaddr),
      .umi_out_data    (umi_out_data)
   );

endmodule

`default_nettype wire

// File: src/umi_beat_fifo.sv
// Synchronous output FIFO for 64-bit beats, with a combinational bypass.
// A write shows at the head on the next cycle; reads come straight from
// the head entry. With bypass high the beat goes directly to the output
// and the status flags follow the output ready.

`default_nettype none
`timescale 1ns/100ps

module umi_beat_fifo (
   input  logic                     umi_in_clk,
   input  logic                     umi_in_nreset,
   input  logic                     bypass,
   input  logic                     beat_valid,
   input  logic                     umi_out_ready,
   umi_pkt_if.rx                    beat,
   output logic                     beat_room,
   output logic                     fifo_full,
   output logic                     fifo_empty,
   output logic                     umi_out_valid,
   output umi_flex_pkg::umi_cmd_t   umi_out_cmd,
   output umi_flex_pkg::umi_addr_t  umi_out_dstaddr,
   output umi_flex_pkg::umi_addr_t  umi_out_srcaddr,
   output umi_flex_pkg::out_data_t  umi_out_data
);

   umi_flex_pkg::fifo_entry_t     mem [umi_flex_pkg::FIFO_DEPTH];
   umi_flex_pkg::fifo_entry_t     wr_entry;
   umi_flex_pkg::fifo_entry_t     head;
   logic [umi_flex_pkg::FIFO_PW-1:0] wr_ptr;
   logic [umi_flex_pkg::FIFO_PW-1:0] rd_ptr;
   logic [umi_flex_pkg::FIFO_PW:0]   count;
   logic                          raw_full;
   logic                          raw_empty;
   logic                          wr_en;
   logic                          rd_en;

   assign raw_full  = count == (umi_flex_pkg::FIFO_PW + 1)'(umi_flex_pkg::FIFO_DEPTH);
   assign raw_empty = count == '0;

   assign beat_room = bypass ? umi_out_ready : ~raw_full;
   assign wr_en     = ~bypass & beat_valid & beat_room;
   assign rd_en     = ~bypass & ~raw_empty & umi_out_ready;

   assign wr_entry = '{cmd: beat.cmd, dstaddr: beat.dstaddr,
                       srcaddr: beat.srcaddr, data: beat.data};

   // ##############################
   // Storage and pointers
   // ##############################
   always_ff @(posedge umi_in_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_entry;
   end

   // Pointers wrap naturally at the power-of-two depth
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head = mem[rd_ptr];

   // ##############################
   // Output mux
   // ##############################
   assign umi_out_valid   = bypass ? beat_valid   : ~raw_empty;
   assign umi_out_cmd     = bypass ? beat.cmd     : head.cmd;
   assign umi_out_dstaddr = bypass ? beat.dstaddr : head.dstaddr;
   assign umi_out_srcaddr = bypass ? beat.srcaddr : head.srcaddr;
   assign umi_out_data    = bypass ? beat.data    : head.data;

   // Bypass reports pushback from the output side
   assign fifo_full  = bypass ? ~umi_out_ready : raw_full;
   assign fifo_empty = bypass ? 1'b1           : raw_empty;

endmodule

`default_nettype wire

// File: src/umi_split_latch.sv
// Remainder registers for a packet being split.
// Capture the leftover command, addresses and data on every beat load
// and present them as the held packet for the next beat.

`default_nettype none
`timescale 1ns/100ps

module umi_split_latch (
   input  logic  umi_in_clk,
   input  logic  umi_in_nreset,
   input  logic  load,
   umi_pkt_if.rx rem,
   umi_pkt_if.tx held
);

   umi_flex_pkg::umi_cmd_t  cmd_q;
   umi_flex_pkg::umi_addr_t dstaddr_q;
   umi_flex_pkg::umi_addr_t srcaddr_q;
   umi_flex_pkg::in_data_t  data_q;

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         cmd_q     <= '0;
         dstaddr_q <= '0;
         srcaddr_q <= '0;
         data_q    <= '0;
      end
      else if (load)
      begin
         cmd_q     <= rem.cmd;
         dstaddr_q <= rem.dstaddr;
         srcaddr_q <= rem.srcaddr;
         data_q    <= rem.data;
      end
   end

   assign held.cmd     = cmd_q;
   assign held.dstaddr = dstaddr_q;
   assign held.srcaddr = srcaddr_q;
   assign held.data    = data_q;

endmodule

`default_nettype wire

// File: src/umi_split_beat.sv
// Beat former for the down-sizing path.
// Takes the current packet from the input or the held remainder and cuts
// the next output beat off it. The leftover packet goes to the latch.
// Element size must be at most 3 and a packet at most 32 bytes.

`default_nettype none
`timescale 1ns/100ps

module umi_split_beat (
   input  logic      use_held,
   umi_pkt_if.rx     pkt_in,
   umi_pkt_if.rx     held,
   output logic      needs_split,
   umi_pkt_if.tx     beat,
   umi_pkt_if.tx     rem
);

   umi_flex_pkg::umi_cmd_t  cur_cmd;
   umi_flex_pkg::umi_addr_t cur_dst;
   umi_flex_pkg::umi_addr_t cur_src;
   umi_flex_pkg::in_data_t  cur_data;
   umi_flex_pkg::umi_cmd_t  beat_cmd;
   umi_flex_pkg::umi_cmd_t  rem_cmd;
   logic [15:0]             byte_count;
   logic [7:0]              step_len;

   // Source select
   assign cur_cmd  = use_held ? held.cmd     : pkt_in.cmd;
   assign cur_dst  = use_held ? held.dstaddr : pkt_in.dstaddr;
   assign cur_src  = use_held ? held.srcaddr : pkt_in.srcaddr;
   assign cur_data = use_held ? held.data    : pkt_in.data;

   // Bytes in packet: (len + 1) << size
   assign byte_count  = {7'd0, {1'b0, cur_cmd.len} + 9'd1} << cur_cmd.size;
   assign needs_split = byte_count > 16'(umi_flex_pkg::ODW_BYTES);

   // Elements per full output beat
   assign step_len = 8'(umi_flex_pkg::ODW_BYTES >> cur_cmd.size);

   // ##############################
   // Command rewrite
   // ##############################
   always_comb
   begin
      beat_cmd    = cur_cmd;
      rem_cmd     = cur_cmd;
      rem_cmd.len = cur_cmd.len - step_len;
      if (needs_split)
      begin
         beat_cmd.len = step_len - 8'd1;
         beat_cmd.eom = 1'b0;
      end
   end

   // Outgoing beat, low slice of the packet
   assign beat.cmd     = beat_cmd;
   assign beat.dstaddr = cur_dst;
   assign beat.srcaddr = cur_src;
   assign beat.data    = cur_data[umi_flex_pkg::ODW-1:0];

   // Leftover, only kept when needs_split
   assign rem.cmd     = rem_cmd;
   assign rem.dstaddr = cur_dst + umi_flex_pkg::umi_addr_t'(umi_flex_pkg::ODW_BYTES);
   assign rem.srcaddr = cur_src + umi_flex_pkg::umi_addr_t'(umi_flex_pkg::ODW_BYTES);
   assign rem.data    = cur_data >> umi_flex_pkg::ODW;

endmodule

`default_nettype wire

// File: src/umi_split_ctrl.sv
// Split control for the width converter.
// Tracks whether a remainder of a split packet is held, picks the beat
// source and produces the input ready and the beat load strobe.

`default_nettype none
`timescale 1ns/100ps

module umi_split_ctrl (
   input  logic umi_in_clk,
   input  logic umi_in_nreset,
   input  logic umi_in_valid,
   input  logic needs_split,
   input  logic beat_room,
   output logic umi_in_ready,
   output logic beat_valid,
   output logic use_held,
   output logic load
);

   logic held_valid;

   // A held remainder always has a beat to offer
   assign beat_valid = umi_in_valid | held_valid;
   assign load       = beat_valid & beat_room;

   // Remainder goes out before the next input packet
   assign use_held     = held_valid;
   assign umi_in_ready = ~held_valid & beat_room;

   // ##############################
   // Held flag
   // ##############################
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         held_valid <= 1'b0;
      else if (load)
         held_valid <= needs_split;
   end

endmodule

`default_nettype wire

// File: src/umi_pkt_if.sv
// UMI packet bundle without handshake: command, both addresses and data.
// The data type is a parameter so one interface serves the wide input
// packets and the narrow output beats.

`default_nettype none
`timescale 1ns/100ps

interface umi_pkt_if #(
   parameter type data_t = umi_flex_pkg::in_data_t
);

   umi_flex_pkg::umi_cmd_t  cmd;
   umi_flex_pkg::umi_addr_t dstaddr;
   umi_flex_pkg::umi_addr_t srcaddr;
   data_t                   data;

   modport tx (output cmd, dstaddr, srcaddr, data);
   modport rx (input cmd, dstaddr, srcaddr, data);

endinterface

`default_nettype wire

// File: src/umi_flex_pkg.sv
// Shared constants and types for the UMI down-sizing width converter.
// Defines the bus widths, the packed command layout and the FIFO word.
// Files refer to these by scoped names; nothing is imported.

`default_nettype none

package umi_flex_pkg;

   // ##############################
   // Bus widths
   // ##############################
   localparam int CW         = 32;
   localparam int AW         = 64;
   localparam int IDW        = 256;
   localparam int ODW        = 64;
   localparam int ODW_BYTES  = ODW / 8;

   // Beat FIFO geometry, depth must be a power of two
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PW    = $clog2(FIFO_DEPTH);

   // ##############################
   // Types
   // ##############################

   // Simplified command, opcode sits in the low bits
   typedef struct packed {
      logic [2:0] hostid;
      logic [1:0] err;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len;
      logic [2:0] size;
      logic [4:0] opcode;
   } umi_cmd_t;

   typedef logic [AW-1:0]  umi_addr_t;
   typedef logic [IDW-1:0] in_data_t;
   typedef logic [ODW-1:0] out_data_t;

   // One output beat as stored in the FIFO
   typedef struct packed {
      umi_cmd_t  cmd;
      umi_addr_t dstaddr;
      umi_addr_t srcaddr;
      out_data_t data;
   } fifo_entry_t;

endpackage

`default_nettype wire
